//--- project.f
+incdir+verilog
verilog/cms_ctrl_pkg.sv
verilog/cms_trace_pkg.sv
verilog/ctrl_regs.sv
verilog/retire_detect.sv
verilog/trace_gate_fsm.sv
verilog/trace_timers.sv
verilog/trace_fifo.sv
verilog/cms_top.sv
dv/cms_tb.sv

//--- Makefile
# Verilator build and run of the trace monitor testbench

TOP := cms_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass only on the pass message"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- dv/cms_tb.sv
// trace monitor testbench
// random core pc/instr stream checked against a cycle model
// of retire, gate, timers and fifo

`timescale 1ns/1ps
`default_nettype none

`include "cms_defs.svh"

module cms_tb import cms_ctrl_pkg::*, cms_trace_pkg::*; ();

    localparam int PERIOD    = 4;
    localparam int WFI_LIMIT = `CMS_WFI_STOP_LIMIT;
    localparam int DEPTH     = `CMS_FIFO_DEPTH;
    localparam int FREE_CYC  = 80;
    localparam int WIN_CYC   = 80;
    localparam int BP_PCS    = 50;
    // trigger, wfi, disabled module, register writes and drains
    localparam int FIXED_CYC  = 400;
    localparam int RUN_CYCLES = FREE_CYC + WIN_CYC + BP_PCS * 4 + FIXED_CYC;

    logic       clk;
    logic       rst_n;
    logic       en;
    pc_t        pc;
    instr_t     instr;
    ctrl_addr_t ctrl_addr;
    pc_t        ctrl_wdata;
    logic       ctrl_we;
    logic       tvalid;
    logic       tready;
    trace_pkt_t tdata;
    logic       tlast;
    logic       overflow;

    // model state
    pc_t          m_pc1;
    pc_t          m_pc2;
    instr_t       m_in1;
    instr_t       m_in2;
    logic         m_start_en;
    logic         m_end_en;
    logic         m_lo_en;
    logic         m_hi_en;
    pc_t          m_start;
    pc_t          m_end;
    pc_t          m_lo;
    pc_t          m_hi;
    logic         m_we_q;
    logic         m_clear;
    trace_state_t m_state;
    int           m_wfi_cnt;
    ts_t          m_ts;
    ts_t          m_last;
    logic         m_ovf;
    trace_pkt_t   exp_q[$];

    int          errors = 0;
    int          beats = 0;
    int          writes = 0;
    logic        ready_random = 1'b0;
    logic [31:0] rng_state = 32'h8638;

    cms_top #(
        .EDGE_TRIGGERED(1'b1)
    ) cms_top_i (
        .clk(clk), .rst_n(rst_n), .en(en), .pc(pc), .instr(instr),
        .ctrl_addr(ctrl_addr), .ctrl_wdata(ctrl_wdata), .ctrl_we(ctrl_we),
        .tvalid(tvalid), .tready(tready), .tdata(tdata),
        .tlast(tlast), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // word aligned and never zero
    function automatic pc_t rand_pc();
        pc_t v;
        v = next_rand();
        v[1:0] = 2'b00;
        if (v == '0) v = 32'h4;
        return v;
    endfunction

    function automatic instr_t rand_instr();
        instr_t v;
        v = next_rand();
        if (v == `CMS_WFI_INSTR) v = v ^ 32'h1;
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [95:0] expv,
                                   input logic [95:0] gotv);
        errors++;
        $display("[ERROR] t=%0t %s expected %h got %h", $time, name, expv, gotv);
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (ready_random) tready = (next_rand() % 2) == 1;
    endtask

    task automatic drive_core(input pc_t p, input instr_t i, input int n);
        pc = p;
        instr = i;
        repeat (n) next_cycle();
    endtask

    task automatic run_random(input int n, input int hold);
        int k;
        for (k = 0; k < n; k++) drive_core(rand_pc(), rand_instr(), hold);
    endtask

    // hold = cycles with ctrl_we high
    task automatic write_reg(input ctrl_addr_t a, input pc_t d, input int hold);
        ctrl_addr = a;
        ctrl_wdata = d;
        ctrl_we = 1'b1;
        repeat (hold) next_cycle();
        ctrl_we = 1'b0;
        next_cycle();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("trace fifo did not drain, %0d packets still expected", exp_q.size());
        end
    endtask

    // zero pc lets the last pc retire
    task automatic flush();
        drive_core('0, '0, 3);
        drain();
    endtask

    // cycle model where the old state decides before everything advances
    always @(posedge clk) begin : model
        logic         ret;
        logic         halted;
        logic         in_win;
        logic         wr;
        logic         pop;
        trace_state_t nxt;
        trace_pkt_t   pkt;
        if (!rst_n) begin
            m_pc1 = '0;
            m_pc2 = '0;
            m_in1 = '0;
            m_in2 = '0;
            m_start_en = 1'b0;
            m_end_en = 1'b0;
            m_lo_en = 1'b0;
            m_hi_en = 1'b0;
            m_start = '0;
            m_end = '1;
            m_lo = '0;
            m_hi = '1;
            m_we_q = 1'b0;
            m_clear = 1'b0;
            m_state = TRACING;
            m_wfi_cnt = 0;
            m_ts = '0;
            m_last = '0;
            m_ovf = 1'b0;
            exp_q.delete();
        end else begin
            ret    = (m_pc2 != m_pc1) && (m_pc2 != '0);
            halted = (m_wfi_cnt == WFI_LIMIT);
            nxt    = m_state;
            if (!m_start_en) nxt = TRACING;
            else if (m_state == TRACING) begin
                if (ret && m_end_en && m_pc2 == m_end) nxt = ENDED;
            end else if (ret && m_pc2 == m_start) nxt = TRACING;
            in_win = (!m_lo_en || m_pc2 >= m_lo) && (!m_hi_en || m_pc2 <= m_hi);
            wr     = en && ret && in_win && !halted && (nxt == TRACING);
            pop    = (exp_q.size() != 0) && tready;
            if (wr) begin
                pkt.instr = m_in2;
                pkt.delta = m_ts - m_last;
                pkt.pc    = m_pc2;
                m_last = m_ts;
                writes++;
                // full fifo drops the packet
                if (exp_q.size() == DEPTH) m_ovf = 1'b1;
                else exp_q.push_back(pkt);
            end
            if (pop) void'(exp_q.pop_front());
            // wfi parking counter
            if (m_clear || m_in2 != `CMS_WFI_INSTR) m_wfi_cnt = 0;
            else if (en && !halted) m_wfi_cnt++;
            m_clear = 1'b0;
            if (ctrl_we && !m_we_q) begin
                case (ctrl_addr)
                    START_EN:   m_start_en = ctrl_wdata[0];
                    END_EN:     m_end_en   = ctrl_wdata[0];
                    START_ADDR: m_start    = ctrl_wdata;
                    END_ADDR:   m_end      = ctrl_wdata;
                    LO_EN:      m_lo_en    = ctrl_wdata[0];
                    HI_EN:      m_hi_en    = ctrl_wdata[0];
                    LO_BOUND:   m_lo       = ctrl_wdata;
                    HI_BOUND:   m_hi       = ctrl_wdata;
                    WFI_CLEAR:  m_clear    = 1'b1;
                    default: ;
                endcase
            end
            m_we_q = ctrl_we;
            m_state = nxt;
            m_ts = m_ts + 1;
            m_pc2 = m_pc1;
            m_in2 = m_in1;
            m_pc1 = pc;
            m_in1 = instr;
        end
    end

    // outputs are settled mid cycle
    always @(negedge clk) begin : check
        if (rst_n) begin
            assert (tvalid === (exp_q.size() != 0))
                else report_mismatch("tvalid", 96'(exp_q.size() != 0), 96'(tvalid));
            assert (overflow === m_ovf)
                else report_mismatch("overflow", 96'(m_ovf), 96'(overflow));
            if (tvalid && exp_q.size() != 0) begin
                assert (tdata.pc === exp_q[0].pc)
                    else report_mismatch("tdata.pc", 96'(exp_q[0].pc), 96'(tdata.pc));
                assert (tdata.instr === exp_q[0].instr)
                    else report_mismatch("tdata.instr", 96'(exp_q[0].instr), 96'(tdata.instr));
                assert (tdata.delta === exp_q[0].delta)
                    else report_mismatch("tdata.delta", 96'(exp_q[0].delta), 96'(tdata.delta));
                assert (tlast === (exp_q[0].instr == `CMS_WFI_INSTR))
                    else report_mismatch("tlast", 96'(exp_q[0].instr == `CMS_WFI_INSTR),
                                         96'(tlast));
                if (tready) beats++;
            end
        end
    end

    initial begin : watchdog
        #(RUN_CYCLES * PERIOD + 100 * PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        pc_t    cur_pc;
        instr_t cur_in;
        pc_t    base;
        pc_t    st;
        pc_t    ed;
        int     i;
        int     r;
        rst_n = 1'b0;
        en = 1'b0;
        pc = '0;
        instr = '0;
        tready = 1'b0;
        ctrl_addr = START_EN;
        ctrl_wdata = '0;
        ctrl_we = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        en = 1'b1;
        tready = 1'b1;

        // no filters with pc changes, repeats and zeros
        cur_pc = rand_pc();
        cur_in = rand_instr();
        for (i = 0; i < FREE_CYC; i++) begin
            r = next_rand() % 8;
            if (r < 5) begin
                cur_pc = rand_pc();
                cur_in = rand_instr();
            end else if (r == 5) begin
                cur_pc = '0;
            end
            drive_core(cur_pc, cur_in, 1);
        end
        flush();

        // module disabled while the core keeps retiring
        en = 1'b0;
        run_random(8, 1);
        drive_core('0, '0, 3);
        en = 1'b1;
        flush();

        // address window around a random base
        base = (next_rand() & 32'hffff_0000) | 32'h100;
        write_reg(LO_BOUND, base + 32'h100, 1);
        write_reg(HI_BOUND, base + 32'h2ff, 1);
        write_reg(LO_EN, 32'h1, 1);
        write_reg(HI_EN, 32'h1, 1);
        for (i = 0; i < WIN_CYC; i++) begin
            drive_core(base + ((next_rand() % 32'h400) & 32'hffff_fffc), rand_instr(), 1);
        end
        flush();
        write_reg(LO_EN, 32'h0, 1);
        write_reg(HI_EN, 32'h0, 1);

        // start/end triggers drop the end packet and keep the start packet
        st = rand_pc();
        ed = rand_pc();
        write_reg(START_ADDR, st, 1);
        write_reg(END_ADDR, ed, 1);
        write_reg(END_EN, 32'h1, 1);
        write_reg(START_EN, 32'h1, 1);
        for (i = 0; i < 2; i++) begin
            run_random(4, 2);
            drive_core(ed, rand_instr(), 2);
            run_random(4, 2);
            drive_core(st, rand_instr(), 2);
        end
        run_random(4, 2);
        flush();
        write_reg(START_EN, 32'h0, 1);
        write_reg(END_EN, 32'h0, 1);

        // short wfi then parked wfi
        run_random(2, 1);
        drive_core(rand_pc(), `CMS_WFI_INSTR, 3);
        run_random(2, 1);
        drive_core(rand_pc(), `CMS_WFI_INSTR, WFI_LIMIT + 8);
        drive_core(rand_pc(), `CMS_WFI_INSTR, 4);
        // clear while still on wfi resumes tracing
        pc = rand_pc();
        write_reg(WFI_CLEAR, '0, 1);
        drive_core(pc, `CMS_WFI_INSTR, 3);
        run_random(2, 1);
        // strobe held high clears once so the core parks again
        pc = rand_pc();
        instr = `CMS_WFI_INSTR;
        write_reg(WFI_CLEAR, '0, WFI_LIMIT + 10);
        run_random(2, 1);
        flush();

        // random back-pressure with sparse retires
        ready_random = 1'b1;
        run_random(BP_PCS, 4);
        flush();
        ready_random = 1'b0;
        tready = 1'b1;
        assert (overflow === 1'b0) else begin
            errors++;
            $display("overflow set during random back-pressure");
        end

        // stalled sink overflows the fifo
        tready = 1'b0;
        run_random(DEPTH + 4, 1);
        drive_core('0, '0, 3);
        assert (overflow === 1'b1) else begin
            errors++;
            $display("overflow not set after filling the stalled fifo");
        end
        tready = 1'b1;
        drain();

        repeat (4) next_cycle();
        $display("writes=%0d beats=%0d errors=%0d", writes, beats, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cms_top.sv
// continuous trace monitor top
// samples core pc/instr, filters retired instructions and
// streams timestamped trace packets out

`timescale 1ns/1ps
`default_nettype none

module cms_top import cms_ctrl_pkg::*, cms_trace_pkg::*; #(
    parameter bit EDGE_TRIGGERED = 1'b1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  pc_t        pc,
    input  instr_t     instr,
    input  ctrl_addr_t ctrl_addr,
    input  pc_t        ctrl_wdata,
    input  logic       ctrl_we,
    output logic       tvalid,
    input  logic       tready,
    output trace_pkt_t tdata,
    output logic       tlast,
    output logic       overflow
);

    // configuration
    logic   start_en;
    logic   end_en;
    logic   lo_en;
    logic   hi_en;
    pc_t    start_addr;
    pc_t    end_addr;
    pc_t    lo_bound;
    pc_t    hi_bound;
    logic   wfi_clear;

    // retire stage
    logic   retire;
    logic   ret_is_wfi;
    pc_t    ret_pc;
    instr_t ret_instr;

    // gate and timers
    logic       wfi_halted;
    ts_t        delta;
    logic       pkt_write;
    trace_pkt_t pkt;

    ctrl_regs #(
        .EDGE_TRIGGERED(EDGE_TRIGGERED)
    ) ctrl_regs_i (
        .clk(clk), .rst_n(rst_n),
        .ctrl_addr(ctrl_addr), .ctrl_wdata(ctrl_wdata), .ctrl_we(ctrl_we),
        .start_en(start_en), .end_en(end_en), .lo_en(lo_en), .hi_en(hi_en),
        .start_addr(start_addr), .end_addr(end_addr),
        .lo_bound(lo_bound), .hi_bound(hi_bound), .wfi_clear(wfi_clear)
    );

    retire_detect retire_detect_i (
        .clk(clk), .rst_n(rst_n), .pc(pc), .instr(instr),
        .retire(retire), .ret_is_wfi(ret_is_wfi),
        .ret_pc(ret_pc), .ret_instr(ret_instr)
    );

    trace_gate_fsm trace_gate_fsm_i (
        .clk(clk), .rst_n(rst_n), .en(en), .retire(retire),
        .ret_pc(ret_pc), .ret_instr(ret_instr), .wfi_halted(wfi_halted),
        .start_en(start_en), .end_en(end_en),
        .start_addr(start_addr), .end_addr(end_addr),
        .lo_en(lo_en), .hi_en(hi_en), .lo_bound(lo_bound), .hi_bound(hi_bound),
        .delta(delta), .pkt_write(pkt_write), .pkt(pkt)
    );

    trace_timers trace_timers_i (
        .clk(clk), .rst_n(rst_n), .en(en), .ret_is_wfi(ret_is_wfi),
        .wfi_clear(wfi_clear), .pkt_write(pkt_write),
        .delta(delta), .wfi_halted(wfi_halted)
    );

    trace_fifo trace_fifo_i (
        .clk(clk), .rst_n(rst_n), .pkt_write(pkt_write), .pkt(pkt),
        .tvalid(tvalid), .tready(tready), .tdata(tdata),
        .tlast(tlast), .overflow(overflow)
    );

endmodule

`default_nettype wire

//--- verilog/trace_fifo.sv
// trace packet fifo
// circular buffer with valid/ready stream out
// drops on full and latches a sticky overflow flag

`timescale 1ns/1ps
`default_nettype none

`include "cms_defs.svh"

module trace_fifo import cms_trace_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pkt_write,
    input  trace_pkt_t pkt,
    output logic       tvalid,
    input  logic       tready,
    output trace_pkt_t tdata,
    output logic       tlast,
    output logic       overflow
);

    localparam int DEPTH = `CMS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    trace_pkt_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(DEPTH));
    // full drops the new packet even on a pop cycle
    assign push = pkt_write && !full;
    assign pop  = tvalid && tready;

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pkt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (pkt_write && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // head entry straight from storage, held while stalled
    assign tvalid = (count != '0);
    assign tdata  = mem[rd_ptr];
    // wfi at the head closes the frame
    assign tlast  = tvalid && (tdata.instr == `CMS_WFI_INSTR);

endmodule

`default_nettype wire

//--- verilog/trace_timers.sv
// trace timers
// free-running timestamp, delta since the last packet
// and the wfi parking counter that halts tracing

`timescale 1ns/1ps
`default_nettype none

`include "cms_defs.svh"

module trace_timers import cms_trace_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic ret_is_wfi,
    input  logic wfi_clear,
    input  logic pkt_write,
    output ts_t  delta,
    output logic wfi_halted
);

    localparam int WFI_CNT_W = $clog2(`CMS_WFI_STOP_LIMIT + 1);

    ts_t                  ts;
    ts_t                  last_ts;
    logic [WFI_CNT_W-1:0] wfi_cnt;

    // timestamp and stamp of the last accepted write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ts      <= '0;
            last_ts <= '0;
        end else begin
            ts <= ts + 1'b1;
            if (pkt_write) begin
                last_ts <= ts;
            end
        end
    end

    // wraps cleanly with modular subtraction
    assign delta = ts - last_ts;

    // count consecutive wfi cycles in stage 2, saturate at the limit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wfi_cnt <= '0;
        end else if (wfi_clear || !ret_is_wfi) begin
            wfi_cnt <= '0;
        end else if (en && !wfi_halted) begin
            wfi_cnt <= wfi_cnt + 1'b1;
        end
    end

    assign wfi_halted = (wfi_cnt == WFI_CNT_W'(`CMS_WFI_STOP_LIMIT));

endmodule

`default_nettype wire

//--- verilog/trace_gate_fsm.sv
// trace gate
// start/end trigger fsm plus address window check
// decides which retired instructions become packets

`timescale 1ns/1ps
`default_nettype none

module trace_gate_fsm import cms_ctrl_pkg::*, cms_trace_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       retire,
    input  pc_t        ret_pc,
    input  instr_t     ret_instr,
    input  logic       wfi_halted,
    input  logic       start_en,
    input  logic       end_en,
    input  pc_t        start_addr,
    input  pc_t        end_addr,
    input  logic       lo_en,
    input  logic       hi_en,
    input  pc_t        lo_bound,
    input  pc_t        hi_bound,
    input  ts_t        delta,
    output logic       pkt_write,
    output trace_pkt_t pkt
);

    trace_state_t state;
    trace_state_t state_nxt;
    logic         start_hit;
    logic         end_hit;
    logic         in_range;

    // trigger matches only on a retiring pc
    assign start_hit = retire && (ret_pc == start_addr);
    assign end_hit   = retire && end_en && (ret_pc == end_addr);

    always_comb begin
        state_nxt = state;
        if (!start_en) begin
            // no start trigger, trace everything
            state_nxt = TRACING;
        end else begin
            case (state)
                WAIT_START, ENDED: begin
                    if (start_hit) state_nxt = TRACING;
                end
                TRACING: begin
                    if (end_hit) state_nxt = ENDED;
                end
                default: state_nxt = TRACING;
            endcase
        end
    end

    // start disabled at reset, so begin tracing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= TRACING;
        end else begin
            state <= state_nxt;
        end
    end

    // disabled bound always passes
    assign in_range = (!lo_en || (ret_pc >= lo_bound)) &&
                      (!hi_en || (ret_pc <= hi_bound));

    // start match packet kept, end match packet dropped
    assign pkt_write = en && retire && in_range && !wfi_halted &&
                       (state_nxt == TRACING);

    assign pkt.instr = ret_instr;
    assign pkt.delta = delta;
    assign pkt.pc    = ret_pc;

endmodule

`default_nettype wire

//--- verilog/retire_detect.sv
// retire detector
// two-stage pc/instruction history, flags a retire when the
// stage-2 pc is nonzero and differs from the stage-1 pc

`timescale 1ns/1ps
`default_nettype none

`include "cms_defs.svh"

module retire_detect import cms_trace_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  pc_t    pc,
    input  instr_t instr,
    output logic   retire,
    output logic   ret_is_wfi,
    output pc_t    ret_pc,
    output instr_t ret_instr
);

    pc_t    pc_s1;
    pc_t    pc_s2;
    instr_t instr_s1;
    instr_t instr_s2;

    // history shift, input of cycle n reaches stage 2 at n+2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_s1    <= '0;
            pc_s2    <= '0;
            instr_s1 <= '0;
            instr_s2 <= '0;
        end else begin
            pc_s1    <= pc;
            instr_s1 <= instr;
            pc_s2    <= pc_s1;
            instr_s2 <= instr_s1;
        end
    end

    // stage 2 retires on its last cycle before the pc moves on
    // zero pc means core not running yet
    assign retire = (pc_s2 != pc_s1) && (pc_s2 != '0);

    assign ret_pc     = pc_s2;
    assign ret_instr  = instr_s2;
    assign ret_is_wfi = (instr_s2 == `CMS_WFI_INSTR);

endmodule

`default_nettype wire

//--- verilog/ctrl_regs.sv
// control register file
// decodes control port writes into trace configuration
// edge or level qualified write strobe

`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import cms_ctrl_pkg::*, cms_trace_pkg::*; #(
    parameter bit EDGE_TRIGGERED = 1'b1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_addr_t ctrl_addr,
    input  pc_t        ctrl_wdata,
    input  logic       ctrl_we,
    output logic       start_en,
    output logic       end_en,
    output logic       lo_en,
    output logic       hi_en,
    output pc_t        start_addr,
    output pc_t        end_addr,
    output pc_t        lo_bound,
    output pc_t        hi_bound,
    output logic       wfi_clear
);

    logic we_q;
    logic we_rise;
    logic wr;

    // previous strobe level for rise detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ctrl_we;
        end
    end

    assign we_rise = ctrl_we & ~we_q;
    // one write per rise, or every cycle in level mode
    assign wr = EDGE_TRIGGERED ? we_rise : ctrl_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_en   <= 1'b0;
            end_en     <= 1'b0;
            lo_en      <= 1'b0;
            hi_en      <= 1'b0;
            start_addr <= '0;
            end_addr   <= '1;
            lo_bound   <= '0;
            hi_bound   <= '1;
            wfi_clear  <= 1'b0;
        end else begin
            // clear pulse lasts a single cycle
            wfi_clear <= 1'b0;
            if (wr) begin
                case (ctrl_addr)
                    START_EN:   start_en   <= ctrl_wdata[0];
                    END_EN:     end_en     <= ctrl_wdata[0];
                    START_ADDR: start_addr <= ctrl_wdata;
                    END_ADDR:   end_addr   <= ctrl_wdata;
                    LO_EN:      lo_en      <= ctrl_wdata[0];
                    HI_EN:      hi_en      <= ctrl_wdata[0];
                    LO_BOUND:   lo_bound   <= ctrl_wdata;
                    HI_BOUND:   hi_bound   <= ctrl_wdata;
                    WFI_CLEAR:  wfi_clear  <= 1'b1;
                    // unmapped addresses ignored
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cms_trace_pkg.sv
// trace monitor data types
// core-side values and the 96-bit trace packet

`default_nettype none

`include "cms_defs.svh"

package cms_trace_pkg;

    typedef logic [`CMS_XLEN-1:0]    pc_t;
    typedef logic [`CMS_INSTR_W-1:0] instr_t;
    typedef logic [`CMS_TS_W-1:0]    ts_t;

    // one retired instruction on the stream
    // instr in the top word, pc in the bottom word
    typedef struct packed {
        instr_t instr;
        ts_t    delta;  // cycles since previous packet
        pc_t    pc;
    } trace_pkt_t;

endpackage

`default_nettype wire

//--- verilog/cms_ctrl_pkg.sv
// trace monitor control types
// register map of the control port and gate fsm states

`default_nettype none

package cms_ctrl_pkg;

    // control port register map
    typedef enum logic [3:0] {
        START_EN   = 4'd0,
        END_EN     = 4'd1,
        START_ADDR = 4'd2,
        END_ADDR   = 4'd3,
        LO_EN      = 4'd4,
        HI_EN      = 4'd5,
        LO_BOUND   = 4'd6,
        HI_BOUND   = 4'd7,
        WFI_CLEAR  = 4'd8
    } ctrl_addr_t;

    // start/end trigger states
    typedef enum logic [1:0] {
        WAIT_START = 2'd0,
        TRACING    = 2'd1,
        ENDED      = 2'd2
    } trace_state_t;

endpackage

`default_nettype wire

//--- verilog/cms_defs.svh
// trace monitor shared constants
// widths, wfi encoding, parking limit and fifo depth

`ifndef CMS_DEFS_SVH
`define CMS_DEFS_SVH

// core-side widths
`define CMS_XLEN 32
`define CMS_INSTR_W 32

// timestamp counter and packet delta
`define CMS_TS_W 32

// wfi opcode, marks end of program
`define CMS_WFI_INSTR 32'h10500073

// cycles parked on wfi before tracing stops
`define CMS_WFI_STOP_LIMIT 16

// packet fifo entries
`define CMS_FIFO_DEPTH 8

`endif
